// ==== fei4_readout.f ====
source/fei4_readout_pkg.sv
source/blink_divider.sv
source/channel_status_led.sv
source/trigger_gate.sv
source/readout_arbiter.sv
source/fei4_readout_top.sv
bench/fei4_readout_assertions.sv
bench/fei4_readout_tb.sv

// ==== Bender.yml ====
package:
  name: fei4_readout

sources:
  - source/fei4_readout_pkg.sv
  - source/blink_divider.sv
  - source/channel_status_led.sv
  - source/trigger_gate.sv
  - source/readout_arbiter.sv
  - source/fei4_readout_top.sv
  - target: simulation
    files:
      - bench/fei4_readout_assertions.sv
      - bench/fei4_readout_tb.sv

// ==== bench/fei4_readout_tb.sv ====
// FE-I4 readout testbench
module fei4_readout_tb
    import fei4_readout_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // short blink periods for simulation
    localparam int SLOW_DIV = 16;
    localparam int FAST_DIV = 6;
    localparam logic [NUM_SOURCES-1:0] ALL_SOURCES = '1;
    // rough length of each test in cycles
    localparam int TEST_CYCLES = 20 + 120 + 120 + 160 + 120 + 240;

    logic CLK_40;
    logic i_rst;
    source_fifo_t src [NUM_SOURCES];
    logic [NUM_SOURCES-1:0] src_enable;
    logic trigger_hold;
    logic out_full;
    logic trigger;
    logic trigger_enable;
    logic ext_trigger_enable;
    logic cmd_ready;
    rx_status_t rx_status [NUM_RX];
    logic clk_locked;
    logic [NUM_SOURCES-1:0] src_read;
    out_word_t out_data;
    logic cmd_start;
    logic busy;
    logic [NUM_RX:0] led;

    // source fifo contents and their reference copies
    event_word_t fifo_q [NUM_SOURCES][$];
    event_word_t shadow_q [NUM_SOURCES][$];
    event_word_t exp_words [$];
    event_word_t got_words [$];
    int exp_last = NUM_SOURCES - 1;
    integer seed = 32'h8853;
    int assert_errors;

    assign assert_errors = dut.u_arbiter.u_checks.error_count
        + dut.u_trigger_gate.u_checks.error_count;

    fei4_readout_top #(
        .SLOW_DIVISOR(SLOW_DIV),
        .FAST_DIVISOR(FAST_DIV)
    ) dut (
        .CLK_40(CLK_40), .i_rst(i_rst),
        .i_src(src), .i_src_enable(src_enable),
        .i_trigger_hold(trigger_hold), .i_out_full(out_full),
        .i_trigger(trigger), .i_trigger_enable(trigger_enable),
        .i_ext_trigger_enable(ext_trigger_enable), .i_cmd_ready(cmd_ready),
        .i_rx_status(rx_status), .i_clk_locked(clk_locked),
        .o_src_read(src_read), .o_out(out_data),
        .o_cmd_start(cmd_start), .o_busy(busy), .o_led(led)
    );

    initial
    begin
        CLK_40 = 1'b0;
        forever #4 CLK_40 = ~CLK_40;
    end

    // fall-through fifo models, pop on the read strobe
    always @(posedge CLK_40)
    begin
        for (int i = 0; i < NUM_SOURCES; i++)
        begin
            if (!i_rst && src_read[i] && fifo_q[i].size() > 0)
                void'(fifo_q[i].pop_front());
            if (fifo_q[i].size() > 0)
                src[i] <= '{not_empty: 1'b1, word: fifo_q[i][0]};
            else
                src[i] <= '{not_empty: 1'b0, word: '0};
        end
    end

    // collect every written output word
    always @(negedge CLK_40)
    begin
        if (!i_rst && out_data.write)
            got_words.push_back(out_data.word);
    end

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, expected);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // stop at the first bound checker failure
    always @(negedge CLK_40)
    begin
        if (assert_errors != 0)
            fail_with("a bound assertion failed");
    end

    initial
    begin
        repeat (2 * TEST_CYCLES) @(posedge CLK_40);
        fail_with("watchdog expired before the tests finished");
    end

    // push random words into a source and its reference copy
    task automatic load_source(input int idx, input int count);
        event_word_t w;
        for (int n = 0; n < count; n++)
        begin
            w = $random(seed);
            fifo_q[idx].push_back(w);
            shadow_q[idx].push_back(w);
        end
    endtask

    // expected word order from the round-robin rule
    task automatic predict_round_robin(input logic [NUM_SOURCES-1:0] mask);
        int idx;
        bit granted;
        granted = 1'b1;
        while (granted)
        begin
            granted = 1'b0;
            for (int k = 1; k <= NUM_SOURCES && !granted; k++)
            begin
                idx = (exp_last + k) % NUM_SOURCES;
                if (mask[idx] && shadow_q[idx].size() > 0)
                begin
                    exp_words.push_back(shadow_q[idx].pop_front());
                    exp_last = idx;
                    granted = 1'b1;
                end
            end
        end
    endtask

    // wait for the predicted words, then compare in order
    task automatic expect_stream();
        int waited;
        waited = 0;
        while (got_words.size() < exp_words.size())
        begin
            @(negedge CLK_40);
            waited++;
            if (waited > 4 * exp_words.size() + 20)
                fail_with("output words did not arrive in time");
        end
        // a few more cycles to catch stray writes
        repeat (3) @(negedge CLK_40);
        check_value("output word count", got_words.size(), exp_words.size());
        foreach (exp_words[i])
            check_value("o_out.word", got_words[i], exp_words[i]);
        exp_words.delete();
        got_words.delete();
    endtask

    task automatic test_round_robin();
        @(negedge CLK_40);
        for (int i = 0; i < NUM_SOURCES; i++)
            load_source(i, 3);
        @(posedge CLK_40);
        src_enable <= ALL_SOURCES;
        predict_round_robin(ALL_SOURCES);
        expect_stream();
    endtask

    task automatic test_enable_and_hold();
        @(posedge CLK_40);
        src_enable <= '0;
        @(negedge CLK_40);
        load_source(0, 3);
        for (int i = 1; i < 4; i++)
            load_source(i, 2);
        @(posedge CLK_40);
        trigger_hold <= 1'b1;
        src_enable <= 6'b110111;
        predict_round_robin(6'b000001);
        expect_stream();
        // trigger fifo empty, hold still up
        repeat (6)
        begin
            @(negedge CLK_40);
            check_value("o_src_read", src_read, 0);
            check_value("o_out.write", out_data.write, 0);
        end
        @(posedge CLK_40);
        trigger_hold <= 1'b0;
        predict_round_robin(6'b110111);
        expect_stream();
        check_value("disabled source depth", fifo_q[3].size(), 2);
        @(negedge CLK_40);
        fifo_q[3].delete();
        shadow_q[3].delete();
        @(posedge CLK_40);
        src_enable <= ALL_SOURCES;
    endtask

    task automatic test_back_pressure();
        int waited;
        @(negedge CLK_40);
        for (int i = 0; i < NUM_SOURCES; i++)
            load_source(i, 4);
        predict_round_robin(ALL_SOURCES);
        waited = 0;
        while (got_words.size() < 5)
        begin
            @(negedge CLK_40);
            waited++;
            if (waited > 40)
                fail_with("stream did not start before back-pressure");
        end
        @(posedge CLK_40);
        out_full <= 1'b1;
        // one registered word may still land
        @(negedge CLK_40);
        check_value("o_src_read", src_read, 0);
        repeat (8)
        begin
            @(negedge CLK_40);
            check_value("o_src_read", src_read, 0);
            check_value("o_out.write", out_data.write, 0);
        end
        @(posedge CLK_40);
        out_full <= 1'b0;
        expect_stream();
    endtask

    // raise the trigger, look for the start pulse, then release
    task automatic fire_trigger(input logic expect_start);
        @(posedge CLK_40);
        trigger <= 1'b1;
        repeat (3)
        begin
            @(negedge CLK_40);
            check_value("o_cmd_start", cmd_start, 0);
        end
        @(negedge CLK_40);
        check_value("o_cmd_start", cmd_start, expect_start);
        @(negedge CLK_40);
        check_value("o_cmd_start", cmd_start, 0);
        @(posedge CLK_40);
        trigger <= 1'b0;
        repeat (4) @(posedge CLK_40);
    endtask

    task automatic test_trigger();
        fire_trigger(1'b1);
        @(negedge CLK_40);
        check_value("o_busy", busy, 1);
        @(posedge CLK_40);
        cmd_ready <= 1'b0;
        // second trigger while busy is dropped
        fire_trigger(1'b0);
        @(negedge CLK_40);
        check_value("o_busy", busy, 1);
        @(posedge CLK_40);
        cmd_ready <= 1'b1;
        @(negedge CLK_40);
        check_value("o_busy", busy, 1);
        @(negedge CLK_40);
        check_value("o_busy", busy, 0);
        // vetoes
        @(posedge CLK_40);
        out_full <= 1'b1;
        fire_trigger(1'b0);
        out_full <= 1'b0;
        trigger_enable <= 1'b0;
        fire_trigger(1'b0);
        trigger_enable <= 1'b1;
        ext_trigger_enable <= 1'b0;
        fire_trigger(1'b0);
        ext_trigger_enable <= 1'b1;
        @(negedge CLK_40);
        check_value("o_busy", busy, 0);
    endtask

    // time three toggles of one LED and check both gaps
    task automatic measure_toggle(input int idx, input int half, input string name);
        logic prev;
        int run;
        int edges;
        @(negedge CLK_40);
        prev = led[idx];
        run = 0;
        edges = 0;
        for (int n = 0; n < 4 * half + 8 && edges < 3; n++)
        begin
            @(negedge CLK_40);
            run++;
            if (led[idx] !== prev)
            begin
                if (edges > 0)
                    check_value(name, run, half);
                edges++;
                run = 0;
                prev = led[idx];
            end
        end
        if (edges < 3)
            fail_with("receiver LED stopped blinking");
    endtask

    task automatic test_leds();
        @(posedge CLK_40);
        rx_status[0] <= '{ready: 1'b0, decoder_err: 1'b0, overflow_err: 1'b1, fifo_full: 1'b1};
        rx_status[1] <= '{ready: 1'b1, decoder_err: 1'b0, overflow_err: 1'b1, fifo_full: 1'b0};
        rx_status[2] <= '{ready: 1'b1, decoder_err: 1'b0, overflow_err: 1'b0, fifo_full: 1'b0};
        rx_status[3] <= '{ready: 1'b1, decoder_err: 1'b1, overflow_err: 1'b0, fifo_full: 1'b0};
        clk_locked <= 1'b0;
        // longer than a slow period
        repeat (2 * SLOW_DIV)
        begin
            @(negedge CLK_40);
            check_value("o_led[0]", led[0], 0);
            check_value("o_led[1]", led[1], 1);
            check_value("o_led[4]", led[NUM_RX], 0);
        end
        measure_toggle(2, SLOW_DIV / 2, "o_led[2] half period");
        measure_toggle(3, FAST_DIV / 2, "o_led[3] half period");
        @(posedge CLK_40);
        clk_locked <= 1'b1;
        out_full <= 1'b1;
        // steady through a whole heartbeat period
        repeat (SLOW_DIV)
        begin
            @(negedge CLK_40);
            check_value("o_led[4]", led[NUM_RX], 1);
        end
        @(posedge CLK_40);
        out_full <= 1'b0;
    endtask

    initial
    begin
        i_rst = 1'b1;
        src_enable = '0;
        trigger_hold = 1'b0;
        out_full = 1'b0;
        trigger = 1'b0;
        trigger_enable = 1'b1;
        ext_trigger_enable = 1'b1;
        cmd_ready = 1'b1;
        clk_locked = 1'b0;
        for (int i = 0; i < NUM_SOURCES; i++)
            src[i] = '0;
        for (int r = 0; r < NUM_RX; r++)
            rx_status[r] = '0;
        repeat (4) @(posedge CLK_40);
        i_rst <= 1'b0;
        test_round_robin();
        test_enable_and_hold();
        test_back_pressure();
        test_trigger();
        test_leds();
        repeat (2) @(negedge CLK_40);
        if (assert_errors != 0)
            fail_with("bound assertions reported errors");
        else
        begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// ==== bench/fei4_readout_assertions.sv ====
// Readout checker assertions
module fei4_readout_assertions
    import fei4_readout_pkg::*;
(
    input logic                   CLK_40,
    input logic                   i_rst,
    input logic [NUM_SOURCES-1:0] i_src_read,
    input logic [NUM_SOURCES-1:0] i_not_empty,
    input logic                   i_out_full,
    input logic                   i_cmd_start,
    input logic                   i_busy
);
    timeunit 1ns;
    timeprecision 100ps;

    // failures so far, polled by the testbench
    int error_count = 0;

    // at most one source popped per cycle
    pop_onehot: assert property (@(posedge CLK_40) disable iff (i_rst) $onehot0(i_src_read))
    else
    begin
        error_count++;
        $error("source read strobe is not one-hot");
    end

    // full output fifo freezes the sources
    pop_blocked: assert property (@(posedge CLK_40) disable iff (i_rst)
        i_out_full |-> (i_src_read == '0))
    else
    begin
        error_count++;
        $error("source read issued while output fifo full");
    end

    // never pop an empty fifo
    pop_has_data: assert property (@(posedge CLK_40) disable iff (i_rst)
        (i_src_read & ~i_not_empty) == '0)
    else
    begin
        error_count++;
        $error("source read issued on an empty fifo");
    end

    // single cycle start, only out of idle
    start_pulse: assert property (@(posedge CLK_40) disable iff (i_rst)
        i_cmd_start |-> (!$past(i_busy) ##1 !i_cmd_start))
    else
    begin
        error_count++;
        $error("command start too long or issued while busy");
    end

endmodule

// arbiter side, trigger ports tied idle
bind readout_arbiter fei4_readout_assertions u_checks (
    .CLK_40     (CLK_40),
    .i_rst      (i_rst),
    .i_src_read (o_src_read),
    .i_not_empty({i_src[5].not_empty, i_src[4].not_empty, i_src[3].not_empty,
                  i_src[2].not_empty, i_src[1].not_empty, i_src[0].not_empty}),
    .i_out_full (i_out_full),
    .i_cmd_start(1'b0),
    .i_busy     (1'b0)
);

// trigger side, no source traffic here
bind trigger_gate fei4_readout_assertions u_checks (
    .CLK_40     (CLK_40),
    .i_rst      (i_rst),
    .i_src_read ('0),
    .i_not_empty('0),
    .i_out_full (i_out_full),
    .i_cmd_start(o_cmd_start),
    .i_busy     (o_busy)
);

// ==== source/fei4_readout_top.sv ====
// FE-I4 readout board top level
module fei4_readout_top
    import fei4_readout_pkg::*;
#(
    parameter int SLOW_DIVISOR = SLOW_BLINK_DIVISOR,
    parameter int FAST_DIVISOR = FAST_BLINK_DIVISOR
)(
    input  logic         CLK_40,
    input  logic         i_rst,

    // event sources: trigger, tdc, four receivers
    input  source_fifo_t i_src [NUM_SOURCES],
    input  logic [NUM_SOURCES-1:0] i_src_enable,
    input  logic         i_trigger_hold,
    // output fifo full level
    input  logic         i_out_full,

    // trigger path
    input  logic         i_trigger,
    input  logic         i_trigger_enable,
    input  logic         i_ext_trigger_enable,
    input  logic         i_cmd_ready,

    // status for the leds
    input  rx_status_t   i_rx_status [NUM_RX],
    input  logic         i_clk_locked,

    // source pops
    output logic [NUM_SOURCES-1:0] o_src_read,
    // merged stream to the output fifo
    output out_word_t    o_out,

    // towards the command sequencer
    output logic         o_cmd_start,
    output logic         o_busy,

    // receivers low, output fifo on top
    output logic [NUM_RX:0] o_led
);

    // merge of all event fifos
    readout_arbiter u_arbiter (
        .CLK_40        (CLK_40),
        .i_rst         (i_rst),
        .i_src         (i_src),
        .i_src_enable  (i_src_enable),
        .i_trigger_hold(i_trigger_hold),
        .i_out_full    (i_out_full),
        .o_src_read    (o_src_read),
        .o_out         (o_out)
    );

    // external trigger to command start
    // output fifo full vetoes new triggers
    trigger_gate u_trigger_gate (
        .CLK_40              (CLK_40),
        .i_rst               (i_rst),
        .i_trigger           (i_trigger),
        .i_trigger_enable    (i_trigger_enable),
        .i_ext_trigger_enable(i_ext_trigger_enable),
        .i_out_full          (i_out_full),
        .i_cmd_ready         (i_cmd_ready),
        .o_cmd_start         (o_cmd_start),
        .o_busy              (o_busy)
    );

    // front panel leds
    channel_status_led #(
        .SLOW_DIVISOR(SLOW_DIVISOR),
        .FAST_DIVISOR(FAST_DIVISOR)
    ) u_status_led (
        .CLK_40      (CLK_40),
        .i_rst       (i_rst),
        .i_rx_status (i_rx_status),
        .i_out_full  (i_out_full),
        .i_clk_locked(i_clk_locked),
        .o_led       (o_led)
    );

endmodule

// ==== source/readout_arbiter.sv ====
// Round-robin readout arbiter
module readout_arbiter
    import fei4_readout_pkg::*;
(
    input  logic         CLK_40,
    input  logic         i_rst,
    // fall-through fifo heads, one per source
    input  source_fifo_t i_src [NUM_SOURCES],
    // host select per source
    input  logic [NUM_SOURCES-1:0] i_src_enable,
    // trigger fifo preempt request
    input  logic         i_trigger_hold,
    // output fifo cannot take a word
    input  logic         i_out_full,
    // pop strobes, one-hot or zero
    output logic [NUM_SOURCES-1:0] o_src_read,
    // registered word, one cycle after the pop
    output out_word_t    o_out
);

    typedef logic [$clog2(NUM_SOURCES)-1:0] src_idx_t;

    logic [NUM_SOURCES-1:0] request;
    logic [NUM_SOURCES-1:0] eligible;
    logic [NUM_SOURCES-1:0] grant;
    src_idx_t               grant_idx;
    src_idx_t               last_grant;
    event_word_t            grant_word;
    logic                   out_write;
    event_word_t            out_word;

    // a source asks when it has data and is selected
    always_comb
    begin
        for (int i = 0; i < NUM_SOURCES; i++)
        begin
            request[i] = i_src[i].not_empty & i_src_enable[i];
        end
    end

    always_comb
    begin
        eligible = request;
        // only the trigger fifo passes during a hold
        if (i_trigger_hold)
        begin
            eligible = '0;
            eligible[SRC_TRIGGER] = request[SRC_TRIGGER];
        end
        // full output fifo stalls everything
        if (i_out_full)
            eligible = '0;
    end

    // search from the slot after the last winner and wrap
    always_comb
    begin
        int idx;
        logic found;
        grant = '0;
        grant_idx = last_grant;
        found = 1'b0;
        for (int k = 1; k <= NUM_SOURCES; k++)
        begin
            idx = int'(last_grant) + k;
            if (idx >= NUM_SOURCES)
                idx = idx - NUM_SOURCES;
            if (!found && eligible[idx])
            begin
                found = 1'b1;
                grant[idx] = 1'b1;
                grant_idx = src_idx_t'(idx);
            end
        end
    end

    // pop in the grant cycle
    assign o_src_read = grant;

    // fall-through head of the winner
    assign grant_word = i_src[grant_idx].word;

    // first search after reset starts at source 0
    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
        begin
            last_grant <= src_idx_t'(NUM_SOURCES - 1);
            out_write <= 1'b0;
        end
        else
        begin
            out_write <= |grant;
            if (|grant)
                last_grant <= grant_idx;
        end
    end

    // data path, loaded only with a grant
    always_ff @(posedge CLK_40)
    begin
        if (|grant)
            out_word <= grant_word;
    end

    assign o_out = '{write: out_write, word: out_word};

endmodule

// ==== source/trigger_gate.sv ====
// External trigger gate
module trigger_gate
    import fei4_readout_pkg::*;
(
    input  logic CLK_40,
    input  logic i_rst,
    // asynchronous trigger input
    input  logic i_trigger,
    input  logic i_trigger_enable,
    // from the command sequencer
    input  logic i_ext_trigger_enable,
    input  logic i_out_full,
    input  logic i_cmd_ready,
    // single cycle start to the command sequencer
    output logic o_cmd_start,
    output logic o_busy
);

    // shift chain, input enters at bit 0
    logic [TRIG_SYNC_STAGES-1:0] trig_sync;
    logic trig_prev;
    logic trig_rise;
    logic ready_prev;
    logic cmd_ack;
    logic accept;

    // synchroniser and edge history
    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
        begin
            trig_sync <= '0;
            trig_prev <= 1'b0;
            ready_prev <= 1'b0;
        end
        else
        begin
            trig_sync <= {trig_sync[TRIG_SYNC_STAGES-2:0], i_trigger};
            trig_prev <= trig_sync[TRIG_SYNC_STAGES-1];
            ready_prev <= i_cmd_ready;
        end
    end

    // rising edge past the last sync stage
    assign trig_rise = trig_sync[TRIG_SYNC_STAGES-1] & ~trig_prev;

    // sequencer ready going high acknowledges the trigger
    assign cmd_ack = i_cmd_ready & ~ready_prev;

    // edges that fail the checks are dropped
    assign accept = trig_rise & i_trigger_enable & i_ext_trigger_enable
        & ~i_out_full & ~o_busy;

    // start and busy rise together
    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
        begin
            o_cmd_start <= 1'b0;
            o_busy <= 1'b0;
        end
        else
        begin
            o_cmd_start <= accept;
            if (accept)
                o_busy <= 1'b1;
            else if (cmd_ack)
                o_busy <= 1'b0;
        end
    end

endmodule

// ==== source/channel_status_led.sv ====
// Receiver and output fifo status LEDs
module channel_status_led
    import fei4_readout_pkg::*;
#(
    parameter int SLOW_DIVISOR = SLOW_BLINK_DIVISOR,
    parameter int FAST_DIVISOR = FAST_BLINK_DIVISOR
)(
    input  logic       CLK_40,
    input  logic       i_rst,
    input  rx_status_t i_rx_status [NUM_RX],
    input  logic       i_out_full,
    input  logic       i_clk_locked,
    // one led per receiver, top bit for the output fifo
    output logic [NUM_RX:0] o_led
);

    logic slow_blink;
    logic fast_blink;

    // default heartbeat
    blink_divider #(
        .DIVISOR(SLOW_DIVISOR)
    ) u_slow_blink (
        .CLK_40 (CLK_40),
        .i_rst  (i_rst),
        .o_blink(slow_blink)
    );

    // decoder error blink
    blink_divider #(
        .DIVISOR(FAST_DIVISOR)
    ) u_fast_blink (
        .CLK_40 (CLK_40),
        .i_rst  (i_rst),
        .o_blink(fast_blink)
    );

    always_comb
    begin
        // dark until the receiver is ready
        // fifo overflow or full lights it steady
        for (int r = 0; r < NUM_RX; r++)
        begin
            o_led[r] = i_rx_status[r].ready
                & ((i_rx_status[r].decoder_err ? fast_blink : slow_blink)
                   | i_rx_status[r].overflow_err
                   | i_rx_status[r].fifo_full);
        end
        // heartbeat or steady on full, only with a locked clock
        o_led[NUM_RX] = (slow_blink | i_out_full) & i_clk_locked;
    end

endmodule

// ==== source/blink_divider.sv ====
// Blink square wave generator
module blink_divider #(
    // full blink period in cycles, at least 4
    parameter int DIVISOR = 4
)(
    input  logic CLK_40,
    input  logic i_rst,
    output logic o_blink
);

    // counter only spans half a period
    typedef logic [$clog2(DIVISOR/2)-1:0] count_t;

    count_t count;

    // toggle once per half period
    // output starts low out of reset
    always_ff @(posedge CLK_40)
    begin
        if (i_rst)
        begin
            count <= '0;
            o_blink <= 1'b0;
        end
        else if (count == count_t'(DIVISOR/2 - 1))
        begin
            // wrap and flip
            count <= '0;
            o_blink <= ~o_blink;
        end
        else
        begin
            count <= count + 1'b1;
        end
    end

endmodule

// ==== source/fei4_readout_pkg.sv ====
// fei4 readout shared definitions
package fei4_readout_pkg;

    // front-end receiver count
    localparam int NUM_RX = 4;

    // arbiter inputs: trigger, tdc, then the receivers
    localparam int NUM_SOURCES = 6;

    // source index map
    localparam int SRC_TRIGGER = 0;
    localparam int SRC_TDC = 1;
    // receiver r is source SRC_RX_BASE + r
    localparam int SRC_RX_BASE = 2;

    // event word width on every fifo
    localparam int WORD_WIDTH = 32;

    // blink periods in CLK_40 cycles
    // 1 Hz at 40 MHz
    localparam int SLOW_BLINK_DIVISOR = 40_000_000;
    // roughly 3 Hz
    localparam int FAST_BLINK_DIVISOR = 13_333_334;

    // flops in the trigger synchroniser
    localparam int TRIG_SYNC_STAGES = 2;

    typedef logic [WORD_WIDTH-1:0] event_word_t;

    // head of one first-word-fall-through source fifo
    typedef struct packed {
        logic        not_empty;
        event_word_t word;
    } source_fifo_t;

    // status levels of one receiver
    typedef struct packed {
        logic ready;
        logic decoder_err;
        logic overflow_err;
        logic fifo_full;
    } rx_status_t;

    // arbiter output towards the output fifo
    typedef struct packed {
        logic        write;
        event_word_t word;
    } out_word_t;

endpackage
